// ==== common/dot_consts.svh ====
`ifndef DOT_CONSTS_SVH
`define DOT_CONSTS_SVH

// Lanes per beat, power of two and at least 2
`define DOT_MAC_NUM 8

// bfloat16 field widths
`define BF16_EXP_WIDTH 8
`define BF16_MAN_WIDTH 7

// Exponent bias
`define BF16_EXP_BIAS 127

`endif

// ==== common/dot_pkg.sv ====
`include "dot_consts.svh"

package dot_pkg;

    typedef struct packed {
        logic                       sign;
        logic [`BF16_EXP_WIDTH-1:0] exp;
        logic [`BF16_MAN_WIDTH-1:0] man;
    } bf16_t;

    localparam bf16_t bf16_zero = '{sign: 1'b0, exp: '0, man: '0};

    // Zero exponent covers both zeros and flushed subnormals
    function automatic logic bf16_is_zero(bf16_t x);
        return x.exp == '0;
    endfunction

    function automatic bf16_t bf16_signed_zero(logic s);
        bf16_t z;
        z = bf16_zero;
        z.sign = s;
        return z;
    endfunction

    function automatic bf16_t bf16_inf(logic s);
        bf16_t z;
        z.sign = s;
        z.exp = '1;
        z.man = '0;
        return z;
    endfunction

endpackage

// ==== hw/fp_add.sv ====
`timescale 1ns/10ps
`include "dot_consts.svh"

module fp_add (
    input  dot_pkg::bf16_t a,
    input  dot_pkg::bf16_t b,
    output dot_pkg::bf16_t z
);
    import dot_pkg::*;

    // Hidden bit and mantissa with as many guard bits below
    localparam int mw = `BF16_MAN_WIDTH + 1;
    localparam int aw = 2 * mw;

    bf16_t                      big;
    bf16_t                      lesser;
    logic [`BF16_EXP_WIDTH-1:0] exp_diff;
    logic [aw-1:0]              big_al;
    logic [aw-1:0]              small_al;
    logic [aw:0]                sum;
    logic [aw:0]                norm;
    int                         lead;
    int                         exp_i;

    // Larger magnitude goes first so the difference never turns negative
    always_comb begin
        if ({a.exp, a.man} >= {b.exp, b.man}) begin
            big = a;
            lesser = b;
        end else begin
            big = b;
            lesser = a;
        end
        exp_diff = big.exp - lesser.exp;
        big_al = {1'b1, big.man, {mw{1'b0}}};
        // Bits shifted past the guard field are lost
        small_al = {1'b1, lesser.man, {mw{1'b0}}} >> exp_diff;
        if (big.sign == lesser.sign) begin
            sum = {1'b0, big_al} + {1'b0, small_al};
        end else begin
            sum = {1'b0, big_al} - {1'b0, small_al};
        end
    end

    // Leading one search and normalization
    always_comb begin
        lead = 0;
        for (int i = 0; i <= aw; i++) begin
            if (sum[i]) begin
                lead = i;
            end
        end
        norm = sum << (aw - lead);
        // Leading one at aw-1 keeps the exponent of the larger operand
        exp_i = int'(big.exp) + lead - (aw - 1);
    end

    always_comb begin
        if (bf16_is_zero(a) && bf16_is_zero(b)) begin
            z = bf16_zero;
        end else if (bf16_is_zero(a)) begin
            z = b;
        end else if (bf16_is_zero(b)) begin
            z = a;
        end else if (sum == '0) begin
            // Exact cancellation
            z = bf16_zero;
        end else if (exp_i >= (1 << `BF16_EXP_WIDTH) - 1) begin
            z = bf16_inf(big.sign);
        end else if (exp_i <= 0) begin
            z = bf16_signed_zero(big.sign);
        end else begin
            z.sign = big.sign;
            z.exp = exp_i[`BF16_EXP_WIDTH-1:0];
            // Truncate below the leading one
            z.man = norm[aw-1 -: `BF16_MAN_WIDTH];
        end
    end

endmodule

// ==== hw/fp_mul.sv ====
`timescale 1ns/10ps
`include "dot_consts.svh"

module fp_mul #(
    parameter int mac_num = `DOT_MAC_NUM
) (
    input  logic                                     clk,
    input  logic                                     rstn,
    input  logic [mac_num*$bits(dot_pkg::bf16_t)-1:0] in_a,
    input  logic [mac_num*$bits(dot_pkg::bf16_t)-1:0] in_b,
    input  logic [mac_num-1:0]                       in_lane_valid,
    input  logic                                     in_last,
    output logic [mac_num*$bits(dot_pkg::bf16_t)-1:0] prod,
    output logic [mac_num-1:0]                       prod_valid,
    output logic                                     prod_last
);
    import dot_pkg::*;

    localparam int bw = $bits(bf16_t);
    localparam int mw = `BF16_MAN_WIDTH + 1;

    logic [mac_num*bw-1:0] prod_nxt;

    function automatic bf16_t mul_lane(bf16_t x, bf16_t y);
        logic                       sgn;
        logic [2*mw-1:0]            p;
        logic [`BF16_MAN_WIDTH-1:0] m;
        int                         e;
        sgn = x.sign ^ y.sign;
        if (bf16_is_zero(x) || bf16_is_zero(y)) begin
            return bf16_signed_zero(sgn);
        end
        p = {1'b1, x.man} * {1'b1, y.man};
        // Product of two 1.x mantissas lies in [1, 4)
        if (p[2*mw-1]) begin
            e = int'(x.exp) + int'(y.exp) - `BF16_EXP_BIAS + 1;
            m = p[2*mw-2 -: `BF16_MAN_WIDTH];
        end else begin
            e = int'(x.exp) + int'(y.exp) - `BF16_EXP_BIAS;
            m = p[2*mw-3 -: `BF16_MAN_WIDTH];
        end
        if (e >= (1 << `BF16_EXP_WIDTH) - 1) begin
            return bf16_inf(sgn);
        end
        if (e <= 0) begin
            return bf16_signed_zero(sgn);
        end
        return '{sign: sgn, exp: e[`BF16_EXP_WIDTH-1:0], man: m};
    endfunction

    always_comb begin
        for (int i = 0; i < mac_num; i++) begin
            if (in_lane_valid[i]) begin
                prod_nxt[i*bw +: bw] = mul_lane(in_a[i*bw +: bw], in_b[i*bw +: bw]);
            end else begin
                prod_nxt[i*bw +: bw] = bf16_zero;
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            prod <= {mac_num{bf16_zero}};
            prod_valid <= '0;
            prod_last <= 1'b0;
        end else begin
            prod <= prod_nxt;
            prod_valid <= in_lane_valid;
            prod_last <= in_last;
        end
    end

endmodule

// ==== fadd_tree/fadd_tree.sv ====
`timescale 1ns/10ps
`include "dot_consts.svh"

module fadd_tree #(
    parameter int mac_num = `DOT_MAC_NUM
) (
    input  logic                                     clk,
    input  logic                                     rstn,
    input  logic [mac_num*$bits(dot_pkg::bf16_t)-1:0] idata,
    input  logic [mac_num-1:0]                       idata_valid,
    input  logic                                     last_in,
    output dot_pkg::bf16_t                           odata,
    output logic                                     odata_valid,
    output logic                                     last_out
);
    import dot_pkg::*;

    localparam int bw = $bits(bf16_t);
    localparam int stage_num = $clog2(mac_num);

    genvar i, j;
    generate
        for (i = 0; i < stage_num; i++) begin : gen_lvl
            localparam int n_in = mac_num >> i;

            bf16_t add_in  [n_in];
            bf16_t add_out [n_in/2];
            logic  lvl_valid;
            logic  lvl_last;

            if (i == 0) begin : gen_first
                // Input register, invalid lanes become +0
                always_ff @(posedge clk or negedge rstn) begin
                    if (!rstn) begin
                        for (int k = 0; k < n_in; k++) begin
                            add_in[k] <= bf16_zero;
                        end
                        lvl_valid <= 1'b0;
                        lvl_last <= 1'b0;
                    end else begin
                        for (int k = 0; k < n_in; k++) begin
                            add_in[k] <= idata_valid[k] ? idata[k*bw +: bw] : bf16_zero;
                        end
                        lvl_valid <= |idata_valid;
                        lvl_last <= last_in;
                    end
                end
            end else begin : gen_next
                // Holds the previous level's sums while that level is idle
                always_ff @(posedge clk or negedge rstn) begin
                    if (!rstn) begin
                        for (int k = 0; k < n_in; k++) begin
                            add_in[k] <= bf16_zero;
                        end
                        lvl_valid <= 1'b0;
                        lvl_last <= 1'b0;
                    end else begin
                        if (gen_lvl[i-1].lvl_valid) begin
                            for (int k = 0; k < n_in; k++) begin
                                add_in[k] <= gen_lvl[i-1].add_out[k];
                            end
                        end
                        lvl_valid <= gen_lvl[i-1].lvl_valid;
                        lvl_last <= gen_lvl[i-1].lvl_last;
                    end
                end
            end

            // Pairs 2j and 2j+1
            for (j = 0; j < n_in/2; j++) begin : gen_add
                fp_add u_fp_add (
                    .a (add_in[2*j]),
                    .b (add_in[2*j+1]),
                    .z (add_out[j])
                );
            end
        end
    endgenerate

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            odata <= bf16_zero;
            odata_valid <= 1'b0;
            last_out <= 1'b0;
        end else begin
            odata <= gen_lvl[stage_num-1].add_out[0];
            odata_valid <= gen_lvl[stage_num-1].lvl_valid;
            last_out <= gen_lvl[stage_num-1].lvl_last;
        end
    end

endmodule

// ==== hw/fp_acc.sv ====
`timescale 1ns/10ps

module fp_acc (
    input  logic           clk,
    input  logic           rstn,
    input  dot_pkg::bf16_t sum_in,
    input  logic           sum_valid,
    input  logic           sum_last,
    output dot_pkg::bf16_t result,
    output logic           result_valid
);
    import dot_pkg::*;

    bf16_t acc;
    bf16_t acc_plus;
    bf16_t next_sum;

    fp_add u_fp_add (
        .a (acc),
        .b (sum_in),
        .z (acc_plus)
    );

    // Beats without a valid lane leave the group sum alone
    assign next_sum = sum_valid ? acc_plus : acc;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            acc <= bf16_zero;
            result <= bf16_zero;
            result_valid <= 1'b0;
        end else begin
            result_valid <= sum_last;
            if (sum_last) begin
                result <= next_sum;
                // Next group starts from +0
                acc <= bf16_zero;
            end else begin
                acc <= next_sum;
            end
        end
    end

endmodule

// ==== hw/dot_engine.sv ====
`timescale 1ns/10ps
`include "dot_consts.svh"

module dot_engine (
    input  logic                                         clk,
    input  logic                                         rstn,
    input  logic [`DOT_MAC_NUM*$bits(dot_pkg::bf16_t)-1:0] in_a,
    input  logic [`DOT_MAC_NUM*$bits(dot_pkg::bf16_t)-1:0] in_b,
    input  logic [`DOT_MAC_NUM-1:0]                       in_lane_valid,
    input  logic                                         in_last,
    output dot_pkg::bf16_t                               dot_result,
    output logic                                         dot_valid
);
    import dot_pkg::*;

    localparam int mac_num = `DOT_MAC_NUM;
    localparam int bw = $bits(bf16_t);

    logic [mac_num*bw-1:0] prod;
    logic [mac_num-1:0]    prod_valid;
    logic                  prod_last;
    bf16_t                 tree_sum;
    logic                  tree_valid;
    logic                  tree_last;

    // 1 cycle
    fp_mul #(
        .mac_num (mac_num)
    ) u_fp_mul (
        .clk           (clk),
        .rstn          (rstn),
        .in_a          (in_a),
        .in_b          (in_b),
        .in_lane_valid (in_lane_valid),
        .in_last       (in_last),
        .prod          (prod),
        .prod_valid    (prod_valid),
        .prod_last     (prod_last)
    );

    // log2(mac_num) + 1 cycles
    fadd_tree #(
        .mac_num (mac_num)
    ) u_fadd_tree (
        .clk         (clk),
        .rstn        (rstn),
        .idata       (prod),
        .idata_valid (prod_valid),
        .last_in     (prod_last),
        .odata       (tree_sum),
        .odata_valid (tree_valid),
        .last_out    (tree_last)
    );

    fp_acc u_fp_acc (
        .clk          (clk),
        .rstn         (rstn),
        .sum_in       (tree_sum),
        .sum_valid    (tree_valid),
        .sum_last     (tree_last),
        .result       (dot_result),
        .result_valid (dot_valid)
    );

endmodule

// ==== tb/dot_engine_tb.sv ====
`timescale 1ns/10ps
`include "dot_consts.svh"

module dot_engine_tb;

    localparam int lanes = `DOT_MAC_NUM;
    localparam int vw = lanes * 16;

    logic             clk = 1'b0;
    logic             rstn = 1'b0;
    logic [vw-1:0]    in_a = '0;
    logic [vw-1:0]    in_b = '0;
    logic [lanes-1:0] in_lane_valid = '0;
    logic             in_last = 1'b0;
    logic [15:0]      dot_result;
    logic             dot_valid;

    int seed = 24;
    int cyc = 0;
    int rst_cnt = 0;
    int errors = 0;
    int timeouts = 0;

    // Beats waiting to be driven, expected results and their due cycles
    logic [vw-1:0]    a_q [$];
    logic [vw-1:0]    b_q [$];
    logic [lanes-1:0] mask_q [$];
    logic             last_q [$];
    logic [15:0]      exp_q [$];
    int               due_q [$];

    logic [15:0]      acc_model = 16'h0000;
    logic [15:0]      last_result = 16'h0000;
    logic             due_now;
    logic [vw-1:0]    nxt_a;
    logic [vw-1:0]    nxt_b;
    logic [lanes-1:0] nxt_mask;
    logic             nxt_last;

    dot_engine dut (
        .clk           (clk),
        .rstn          (rstn),
        .in_a          (in_a),
        .in_b          (in_b),
        .in_lane_valid (in_lane_valid),
        .in_last       (in_last),
        .dot_result    (dot_result),
        .dot_valid     (dot_valid)
    );

    always #50 clk = ~clk;

    // Overflow to infinity and underflow to signed zero
    function automatic logic [15:0] pack_result(logic s, int e, logic [6:0] m);
        if (e >= 255) begin
            return {s, 8'hff, 7'd0};
        end
        if (e <= 0) begin
            return {s, 15'd0};
        end
        return {s, e[7:0], m};
    endfunction

    function automatic logic [15:0] bf_mul(logic [15:0] x, logic [15:0] y);
        logic s;
        int   p;
        int   e;
        s = x[15] ^ y[15];
        if (x[14:7] == 8'd0 || y[14:7] == 8'd0) begin
            return {s, 15'd0};
        end
        p = int'({1'b1, x[6:0]}) * int'({1'b1, y[6:0]});
        e = int'(x[14:7]) + int'(y[14:7]) - 127;
        if (p >= 32768) begin
            e = e + 1;
            p = p >> 8;
        end else begin
            p = p >> 7;
        end
        return pack_result(s, e, p[6:0]);
    endfunction

    // Alignment keeps 8 guard bits and drops anything below
    function automatic logic [15:0] bf_add(logic [15:0] x, logic [15:0] y);
        logic [15:0] hi;
        logic [15:0] lo;
        int          d;
        int          mh;
        int          ml;
        int          s;
        int          lead;
        int          e;
        if (x[14:7] == 8'd0 && y[14:7] == 8'd0) begin
            return 16'h0000;
        end
        if (x[14:7] == 8'd0) begin
            return y;
        end
        if (y[14:7] == 8'd0) begin
            return x;
        end
        if (x[14:0] >= y[14:0]) begin
            hi = x;
            lo = y;
        end else begin
            hi = y;
            lo = x;
        end
        d = int'(hi[14:7]) - int'(lo[14:7]);
        mh = int'({1'b1, hi[6:0]}) << 8;
        ml = (d > 15) ? 0 : (int'({1'b1, lo[6:0]}) << 8) >> d;
        s = (hi[15] == lo[15]) ? mh + ml : mh - ml;
        if (s == 0) begin
            return 16'h0000;
        end
        lead = 0;
        for (int i = 0; i < 18; i++) begin
            if (s[i]) begin
                lead = i;
            end
        end
        e = int'(hi[14:7]) + lead - 15;
        if (lead >= 7) begin
            s = s >> (lead - 7);
        end else begin
            s = s << (7 - lead);
        end
        return pack_result(hi[15], e, s[6:0]);
    endfunction

    // Products of one beat, reduced pairwise level by level
    function automatic logic [15:0] beat_sum(logic [vw-1:0] a, logic [vw-1:0] b,
                                             logic [lanes-1:0] mask);
        logic [15:0] v [lanes];
        int          n;
        for (int i = 0; i < lanes; i++) begin
            v[i] = mask[i] ? bf_mul(a[i*16 +: 16], b[i*16 +: 16]) : 16'h0000;
        end
        n = lanes;
        while (n > 1) begin
            for (int j = 0; j < n / 2; j++) begin
                v[j] = bf_add(v[2*j], v[2*j+1]);
            end
            n = n / 2;
        end
        return v[0];
    endfunction

    task automatic push_beat(logic [vw-1:0] a, logic [vw-1:0] b, logic [lanes-1:0] mask,
                             logic last);
        a_q.push_back(a);
        b_q.push_back(b);
        mask_q.push_back(mask);
        last_q.push_back(last);
        if (mask != '0) begin
            acc_model = bf_add(acc_model, beat_sum(a, b, mask));
        end
        if (last) begin
            exp_q.push_back(acc_model);
            acc_model = 16'h0000;
        end
    endtask

    task automatic idle(int n);
        for (int k = 0; k < n; k++) begin
            push_beat('0, '0, '0, 1'b0);
        end
    endtask

    // Exponents from 100 to 140 and roughly one zero operand in 16
    task automatic rand_operand(output logic [15:0] v);
        int r;
        int e;
        r = $random(seed);
        e = 100 + int'(r[27:12] % 16'd41);
        v = {r[31], e[7:0], r[6:0]};
        if (r[11:8] == 4'd0) begin
            v[14:0] = 15'd0;
        end
    endtask

    task automatic rand_lanes(output logic [vw-1:0] a, output logic [vw-1:0] b);
        logic [15:0] x;
        logic [15:0] y;
        for (int i = 0; i < lanes; i++) begin
            rand_operand(x);
            rand_operand(y);
            a[i*16 +: 16] = x;
            b[i*16 +: 16] = y;
        end
    endtask

    task automatic random_group(int beats, logic partial);
        logic [vw-1:0]    a;
        logic [vw-1:0]    b;
        logic [lanes-1:0] mask;
        int               r;
        for (int k = 0; k < beats; k++) begin
            rand_lanes(a, b);
            mask = '1;
            if (partial) begin
                r = $random(seed);
                mask = r[lanes-1:0];
            end
            push_beat(a, b, mask, k == beats - 1);
        end
    endtask

    // Odd lanes carry the negated even operand, so each pair cancels
    task automatic cancel_beat(logic [lanes-1:0] mask, logic last);
        logic [vw-1:0] a;
        logic [vw-1:0] b;
        rand_lanes(a, b);
        for (int j = 0; j < lanes / 2; j++) begin
            a[(2*j+1)*16 +: 16] = a[2*j*16 +: 16] ^ 16'h8000;
            b[(2*j+1)*16 +: 16] = b[2*j*16 +: 16];
        end
        push_beat(a, b, mask, last);
    endtask

    // Reset for 5 edges and then one queued beat per cycle
    always @(posedge clk) begin
        if (rst_cnt < 5) begin
            rst_cnt <= rst_cnt + 1;
            if (rst_cnt == 4) begin
                rstn <= 1'b1;
            end
        end else if (mask_q.size() > 0) begin
            nxt_a = a_q.pop_front();
            nxt_b = b_q.pop_front();
            nxt_mask = mask_q.pop_front();
            nxt_last = last_q.pop_front();
            in_a <= nxt_a;
            in_b <= nxt_b;
            in_lane_valid <= nxt_mask;
            in_last <= nxt_last;
            if (nxt_last) begin
                due_q.push_back(cyc + 6);
            end
        end else begin
            in_lane_valid <= '0;
            in_last <= 1'b0;
        end
    end

    // Outputs are checked at the falling edge
    always @(negedge clk) begin
        due_now = (due_q.size() > 0) && (due_q[0] == cyc);
        if (due_now) begin
            assert (dot_valid === 1'b1) else begin
                errors++;
                $display("No dot_valid pulse at time %0t where a result was due", $time);
            end
            last_result = exp_q.pop_front();
            void'(due_q.pop_front());
        end else begin
            assert (dot_valid === 1'b0) else begin
                errors++;
                $display("Unexpected dot_valid pulse at time %0t", $time);
            end
        end
        // Result register holds its value between pulses
        assert (dot_result === last_result) else begin
            errors++;
            $display("Mismatch at time %0t: dot_result expected %h, actual %h",
                     $time, last_result, dot_result);
        end
        cyc = cyc + 1;
    end

    initial begin
        logic [vw-1:0]    a;
        logic [vw-1:0]    b;
        int               r;
        int               n;
        int               limit;

        idle(4);

        // Single beat with all lanes valid
        rand_lanes(a, b);
        push_beat(a, b, '1, 1'b1);
        idle(8);

        // Idle gap inside a group
        rand_lanes(a, b);
        push_beat(a, b, '1, 1'b0);
        idle(3);
        rand_lanes(a, b);
        push_beat(a, b, '1, 1'b1);
        idle(2);

        // Last beat with an empty mask still closes the group
        rand_lanes(a, b);
        push_beat(a, b, '1, 1'b0);
        rand_lanes(a, b);
        push_beat(a, b, 8'h5a, 1'b0);
        rand_lanes(a, b);
        push_beat(a, b, '0, 1'b1);
        idle(1);

        // Group without any valid lane gives +0
        push_beat(a, b, '0, 1'b0);
        push_beat(a, b, '0, 1'b1);
        idle(2);

        for (int g = 0; g < 6; g++) begin
            r = $random(seed);
            random_group(2 + int'(r[1:0]), 1'b0);
            idle(int'(r[5:4]) % 3);
        end

        for (int g = 0; g < 6; g++) begin
            r = $random(seed);
            random_group(1 + int'(r[1:0]), 1'b1);
            idle(1);
        end

        cancel_beat('1, 1'b1);
        r = $random(seed);
        cancel_beat(r[lanes-1:0], 1'b1);
        rand_lanes(a, b);
        push_beat(a, b, 8'h0f, 1'b0);
        cancel_beat('1, 1'b1);
        idle(3);

        // Back to back groups with several in flight
        for (int g = 0; g < 12; g++) begin
            r = $random(seed);
            random_group(1 + int'(r[1:0]), r[8]);
        end

        limit = mask_q.size() + 20;
        n = 0;
        while (mask_q.size() > 0 && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (mask_q.size() > 0) begin
            timeouts++;
            $display("Timeout while driving stimulus, %0d beats left", mask_q.size());
        end

        n = 0;
        while (exp_q.size() > 0 && n < 20) begin
            @(posedge clk);
            n++;
        end
        if (exp_q.size() > 0) begin
            timeouts++;
            $display("Timeout waiting for results, %0d still outstanding", exp_q.size());
        end

        // A few quiet cycles to catch stray pulses
        repeat (8) @(posedge clk);

        $display("Check errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== dot_engine.f ====
+incdir+common
common/dot_pkg.sv
hw/fp_add.sv
hw/fp_mul.sv
fadd_tree/fadd_tree.sv
hw/fp_acc.sv
hw/dot_engine.sv
tb/dot_engine_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f dot_engine.f --top-module dot_engine_tb -o dot_engine_sim
out=$(./obj_dir/dot_engine_sim)
echo "$out"

if echo "$out" | grep -q "Test completed successfully"; then
    exit 0
fi
exit 1
